// ==== common/soc_mem_pkg.sv ====
package soc_mem_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 64;
  localparam int strb_w = data_w / 8;
  localparam int lfsr_w = 20;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [strb_w-1:0] strb_t;
  typedef logic [1:0] resp_t;
  typedef logic [lfsr_w-1:0] lfsr_t;

  // axi response codes
  localparam resp_t resp_okay = 2'b00;
  localparam resp_t resp_decerr = 2'b11;

  // address map
  // sram owns everything from its base upward, so it aliases past its depth
  localparam addr_t sram_base = 32'h8000_0000;
  localparam addr_t uart_base = 32'h1000_0000;
  localparam addr_t uart_span = 32'd16;

endpackage

// ==== common/axi_lite_if.sv ====
interface axi_lite_if;

  // write address
  logic awvalid;
  logic awready;
  soc_mem_pkg::addr_t awaddr;

  // write data
  logic wvalid;
  logic wready;
  soc_mem_pkg::data_t wdata;
  soc_mem_pkg::strb_t wstrb;

  // write response
  logic bvalid;
  logic bready;
  soc_mem_pkg::resp_t bresp;

  // read address
  logic arvalid;
  logic arready;
  soc_mem_pkg::addr_t araddr;

  // read data
  logic rvalid;
  logic rready;
  soc_mem_pkg::data_t rdata;
  soc_mem_pkg::resp_t rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output arvalid, araddr, rready,
    input awready, wready, bvalid, bresp,
    input arready, rvalid, rdata, rresp
  );

  modport slave (
    input awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input arvalid, araddr, rready,
    output awready, wready, bvalid, bresp,
    output arready, rvalid, rdata, rresp
  );

endinterface

// ==== verilog/stall_lfsr.sv ====
module stall_lfsr #(
  parameter soc_mem_pkg::lfsr_t SEED = 20'h00065,
  parameter bit STALL_EN = 1'b1
) (
  input  logic clk,
  input  logic rst_n_i,
  output logic go_o
);

  soc_mem_pkg::lfsr_t lfsr_q;

  // fibonacci, taps 19 and 18
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      lfsr_q <= SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[18]};
    end
  end

  assign go_o = STALL_EN ? lfsr_q[19] : 1'b1;

endmodule

// ==== sram/axi_sram_slave.sv ====
module axi_sram_slave #(
  parameter int MEM_WORDS = 1024,
  parameter bit STALL_EN = 1'b1,
  parameter soc_mem_pkg::lfsr_t SEED = 20'h00065
) (
  input logic clk,
  input logic rst_n_i,
  axi_lite_if.slave bus
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  soc_mem_pkg::data_t mem [MEM_WORDS];

  logic go;
  logic busy;
  logic rd_fire;
  logic wr_fire;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  logic bvalid_q;
  logic rvalid_q;
  soc_mem_pkg::data_t rdata_q;

  // word index from bits above the byte offset, wrapped to the depth
  function automatic logic [IDX_W-1:0] word_index(input soc_mem_pkg::addr_t addr);
    logic [28:0] word;
    logic [31:0] wrapped;
    word = addr[31:3];
    wrapped = 32'(word) % 32'(MEM_WORDS);
    return wrapped[IDX_W-1:0];
  endfunction

  stall_lfsr #(
    .SEED     (SEED),
    .STALL_EN (STALL_EN)
  ) u_stall (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .go_o    (go)
  );

  // one outstanding response at a time
  assign busy = bvalid_q | rvalid_q;

  assign bus.arready = go & ~busy & bus.arvalid;
  assign bus.awready = go & ~busy & ~bus.arvalid & bus.awvalid & bus.wvalid;
  assign bus.wready = bus.awready;

  assign rd_fire = bus.arvalid & bus.arready;
  assign wr_fire = bus.awvalid & bus.awready;

  assign rd_idx = word_index(bus.araddr);
  assign wr_idx = word_index(bus.awaddr);

  assign bus.bvalid = bvalid_q;
  assign bus.bresp = soc_mem_pkg::resp_okay;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata = rdata_q;
  assign bus.rresp = soc_mem_pkg::resp_okay;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && bus.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && bus.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // registered read, held while rvalid waits
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= mem[rd_idx];
    end
  end

  // byte-lane writes
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int i = 0; i < soc_mem_pkg::strb_w; i++) begin
        if (bus.wstrb[i]) begin
          mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

// ==== uart/axi_uart_slave.sv ====
module axi_uart_slave #(
  parameter bit STALL_EN = 1'b1,
  parameter soc_mem_pkg::lfsr_t SEED = 20'h5a3c1
) (
  input  logic clk,
  input  logic rst_n_i,
  axi_lite_if.slave bus,
  output logic tx_valid_o,
  output logic [7:0] tx_data_o
);

  logic go;
  logic busy;
  logic rd_fire;
  logic wr_fire;

  logic bvalid_q;
  logic rvalid_q;
  logic [31:0] sent_q;
  soc_mem_pkg::data_t rdata_q;

  stall_lfsr #(
    .SEED     (SEED),
    .STALL_EN (STALL_EN)
  ) u_stall (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .go_o    (go)
  );

  assign busy = bvalid_q | rvalid_q;

  assign bus.arready = go & ~busy & bus.arvalid;
  assign bus.awready = go & ~busy & ~bus.arvalid & bus.awvalid & bus.wvalid;
  assign bus.wready = bus.awready;

  assign rd_fire = bus.arvalid & bus.arready;
  assign wr_fire = bus.awvalid & bus.awready;

  // byte goes out in the accept cycle, only lane 0 counts
  assign tx_valid_o = wr_fire & bus.wstrb[0];
  assign tx_data_o = bus.wdata[7:0];

  assign bus.bvalid = bvalid_q;
  assign bus.bresp = soc_mem_pkg::resp_okay;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata = rdata_q;
  assign bus.rresp = soc_mem_pkg::resp_okay;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      sent_q <= '0;
    end else begin
      if (tx_valid_o) begin
        sent_q <= sent_q + 32'd1;
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && bus.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && bus.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // status word is the sent count
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= {32'h0, sent_q};
    end
  end

endmodule

// ==== verilog/axi_addr_decode.sv ====
module axi_addr_decode (
  input logic clk,
  input logic rst_n_i,
  axi_lite_if.slave up,
  axi_lite_if.master sram,
  axi_lite_if.master uart
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_read = 2'd1;
  localparam logic [1:0] st_write = 2'd2;
  localparam logic [1:0] st_error = 2'd3;

  logic [1:0] state_q;
  logic tgt_uart_q;
  logic is_wr_q;
  logic req_sent_q;
  soc_mem_pkg::addr_t addr_q;
  soc_mem_pkg::data_t wdata_q;
  soc_mem_pkg::strb_t wstrb_q;

  logic accept_rd;
  logic accept_wr;
  soc_mem_pkg::addr_t req_addr;
  logic hit_sram;
  logic hit_uart;
  logic req_fire;
  logic rsp_fire;

  // reads win when both are pending
  assign accept_rd = (state_q == st_idle) & up.arvalid;
  assign accept_wr = (state_q == st_idle) & ~up.arvalid & up.awvalid & up.wvalid;

  assign up.arready = accept_rd;
  assign up.awready = accept_wr;
  assign up.wready = accept_wr;

  assign req_addr = accept_rd ? up.araddr : up.awaddr;
  assign hit_sram = req_addr >= soc_mem_pkg::sram_base;
  assign hit_uart = (req_addr >= soc_mem_pkg::uart_base) &&
                    (req_addr < soc_mem_pkg::uart_base + soc_mem_pkg::uart_span);

  // requests toward the slaves, held until their handshake
  assign sram.arvalid = (state_q == st_read) & ~tgt_uart_q & ~req_sent_q;
  assign sram.awvalid = (state_q == st_write) & ~tgt_uart_q & ~req_sent_q;
  assign sram.wvalid = sram.awvalid;
  assign uart.arvalid = (state_q == st_read) & tgt_uart_q & ~req_sent_q;
  assign uart.awvalid = (state_q == st_write) & tgt_uart_q & ~req_sent_q;
  assign uart.wvalid = uart.awvalid;

  assign sram.araddr = addr_q;
  assign sram.awaddr = addr_q;
  assign sram.wdata = wdata_q;
  assign sram.wstrb = wstrb_q;
  assign uart.araddr = addr_q;
  assign uart.awaddr = addr_q;
  assign uart.wdata = wdata_q;
  assign uart.wstrb = wstrb_q;

  assign sram.bready = up.bready & (state_q == st_write) & ~tgt_uart_q;
  assign sram.rready = up.rready & (state_q == st_read) & ~tgt_uart_q;
  assign uart.bready = up.bready & (state_q == st_write) & tgt_uart_q;
  assign uart.rready = up.rready & (state_q == st_read) & tgt_uart_q;

  // responses mirrored back, decerr generated locally
  always_comb begin
    up.bvalid = 1'b0;
    up.bresp = soc_mem_pkg::resp_okay;
    up.rvalid = 1'b0;
    up.rdata = '0;
    up.rresp = soc_mem_pkg::resp_okay;
    case (state_q)
      st_read: begin
        up.rvalid = tgt_uart_q ? uart.rvalid : sram.rvalid;
        up.rdata = tgt_uart_q ? uart.rdata : sram.rdata;
        up.rresp = tgt_uart_q ? uart.rresp : sram.rresp;
      end
      st_write: begin
        up.bvalid = tgt_uart_q ? uart.bvalid : sram.bvalid;
        up.bresp = tgt_uart_q ? uart.bresp : sram.bresp;
      end
      st_error: begin
        up.bvalid = is_wr_q;
        up.bresp = soc_mem_pkg::resp_decerr;
        up.rvalid = ~is_wr_q;
        up.rresp = soc_mem_pkg::resp_decerr;
      end
      default: ;
    endcase
  end

  assign req_fire = (sram.arvalid & sram.arready) | (sram.awvalid & sram.awready) |
                    (uart.arvalid & uart.arready) | (uart.awvalid & uart.awready);
  assign rsp_fire = (up.bvalid & up.bready) | (up.rvalid & up.rready);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
      tgt_uart_q <= 1'b0;
      is_wr_q <= 1'b0;
      req_sent_q <= 1'b0;
    end else if (accept_rd || accept_wr) begin
      tgt_uart_q <= hit_uart;
      is_wr_q <= accept_wr;
      req_sent_q <= 1'b0;
      if (!(hit_sram || hit_uart)) begin
        state_q <= st_error;
      end else begin
        state_q <= accept_rd ? st_read : st_write;
      end
    end else begin
      if (req_fire) begin
        req_sent_q <= 1'b1;
      end
      if (rsp_fire) begin
        state_q <= st_idle;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept_rd || accept_wr) begin
      addr_q <= req_addr;
      wdata_q <= up.wdata;
      wstrb_q <= up.wstrb;
    end
  end

endmodule

// ==== verilog/soc_mem_top.sv ====
module soc_mem_top #(
  parameter int MEM_WORDS = 1024,
  parameter bit STALL_EN = 1'b1,
  parameter soc_mem_pkg::lfsr_t SRAM_SEED = 20'h00065,
  parameter soc_mem_pkg::lfsr_t UART_SEED = 20'h5a3c1
) (
  input  logic clk,
  input  logic rst_n_i,

  input  logic s_awvalid_i,
  output logic s_awready_o,
  input  soc_mem_pkg::addr_t s_awaddr_i,

  input  logic s_wvalid_i,
  output logic s_wready_o,
  input  soc_mem_pkg::data_t s_wdata_i,
  input  soc_mem_pkg::strb_t s_wstrb_i,

  output logic s_bvalid_o,
  input  logic s_bready_i,
  output soc_mem_pkg::resp_t s_bresp_o,

  input  logic s_arvalid_i,
  output logic s_arready_o,
  input  soc_mem_pkg::addr_t s_araddr_i,

  output logic s_rvalid_o,
  input  logic s_rready_i,
  output soc_mem_pkg::data_t s_rdata_o,
  output soc_mem_pkg::resp_t s_rresp_o,

  output logic uart_tx_valid_o,
  output logic [7:0] uart_tx_data_o
);

  axi_lite_if up_bus ();
  axi_lite_if sram_bus ();
  axi_lite_if uart_bus ();

  // external master side
  assign up_bus.awvalid = s_awvalid_i;
  assign up_bus.awaddr = s_awaddr_i;
  assign up_bus.wvalid = s_wvalid_i;
  assign up_bus.wdata = s_wdata_i;
  assign up_bus.wstrb = s_wstrb_i;
  assign up_bus.bready = s_bready_i;
  assign up_bus.arvalid = s_arvalid_i;
  assign up_bus.araddr = s_araddr_i;
  assign up_bus.rready = s_rready_i;

  assign s_awready_o = up_bus.awready;
  assign s_wready_o = up_bus.wready;
  assign s_bvalid_o = up_bus.bvalid;
  assign s_bresp_o = up_bus.bresp;
  assign s_arready_o = up_bus.arready;
  assign s_rvalid_o = up_bus.rvalid;
  assign s_rdata_o = up_bus.rdata;
  assign s_rresp_o = up_bus.rresp;

  axi_addr_decode u_decode (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .up      (up_bus.slave),
    .sram    (sram_bus.master),
    .uart    (uart_bus.master)
  );

  axi_sram_slave #(
    .MEM_WORDS (MEM_WORDS),
    .STALL_EN  (STALL_EN),
    .SEED      (SRAM_SEED)
  ) u_sram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bus     (sram_bus.slave)
  );

  axi_uart_slave #(
    .STALL_EN (STALL_EN),
    .SEED     (UART_SEED)
  ) u_uart (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .bus        (uart_bus.slave),
    .tx_valid_o (uart_tx_valid_o),
    .tx_data_o  (uart_tx_data_o)
  );

endmodule

// ==== bench/tb_soc_mem.sv ====
module tb_soc_mem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_words = 1024;

  logic clk;
  logic rst_n_i;
  logic s_awvalid_i;
  logic s_awready_o;
  soc_mem_pkg::addr_t s_awaddr_i;
  logic s_wvalid_i;
  logic s_wready_o;
  soc_mem_pkg::data_t s_wdata_i;
  soc_mem_pkg::strb_t s_wstrb_i;
  logic s_bvalid_o;
  logic s_bready_i;
  soc_mem_pkg::resp_t s_bresp_o;
  logic s_arvalid_i;
  logic s_arready_o;
  soc_mem_pkg::addr_t s_araddr_i;
  logic s_rvalid_o;
  logic s_rready_i;
  soc_mem_pkg::data_t s_rdata_o;
  soc_mem_pkg::resp_t s_rresp_o;
  logic uart_tx_valid_o;
  logic [7:0] uart_tx_data_o;

  int errors = 0;
  int cycles = 0;
  int limit = 0;
  logic [7:0] tx_q[$];
  logic [7:0] exp_tx[$];

  soc_mem_top #(
    .MEM_WORDS (mem_words),
    .STALL_EN  (1'b1)
  ) soc_mem_top_i (.*);

  always #50 clk = ~clk;

  // guard against a handshake that never completes
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // tx strobe is stable by the falling edge
  always @(negedge clk) begin
    if (rst_n_i && uart_tx_valid_o) begin
      tx_q.push_back(uart_tx_data_o);
    end
  end

  task automatic check_data(input string what, input soc_mem_pkg::data_t exp,
                            input soc_mem_pkg::data_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_resp(input string what, input soc_mem_pkg::resp_t exp,
                            input soc_mem_pkg::resp_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %0d got %0d", $time, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, act);
      errors++;
    end
  endtask

  // entered and left 5 ns after a rising edge
  task automatic axi_write(input soc_mem_pkg::addr_t addr, input soc_mem_pkg::data_t data,
                           input soc_mem_pkg::strb_t strb, output soc_mem_pkg::resp_t resp);
    s_awvalid_i = 1'b1;
    s_awaddr_i = addr;
    s_wvalid_i = 1'b1;
    s_wdata_i = data;
    s_wstrb_i = strb;
    do @(negedge clk); while (!s_awready_o);
    if (!s_wready_o) begin
      $display("write data to %h was not taken together with its address at %0t",
               addr, $time);
      errors++;
    end
    @(posedge clk);
    #5;
    s_awvalid_i = 1'b0;
    s_wvalid_i = 1'b0;
    do @(negedge clk); while (!s_bvalid_o);
    repeat ($urandom_range(3, 0)) @(posedge clk);
    @(posedge clk);
    #5;
    s_bready_i = 1'b1;
    @(negedge clk);
    resp = s_bresp_o;
    @(posedge clk);
    #5;
    s_bready_i = 1'b0;
    if (s_bvalid_o) begin
      $display("write to %h gave a second response at %0t", addr, $time);
      errors++;
    end
  endtask

  task automatic axi_read(input soc_mem_pkg::addr_t addr, output soc_mem_pkg::data_t data,
                          output soc_mem_pkg::resp_t resp);
    s_arvalid_i = 1'b1;
    s_araddr_i = addr;
    do @(negedge clk); while (!s_arready_o);
    @(posedge clk);
    #5;
    s_arvalid_i = 1'b0;
    do @(negedge clk); while (!s_rvalid_o);
    repeat ($urandom_range(3, 0)) @(posedge clk);
    @(posedge clk);
    #5;
    s_rready_i = 1'b1;
    @(negedge clk);
    data = s_rdata_o;
    resp = s_rresp_o;
    @(posedge clk);
    #5;
    s_rready_i = 1'b0;
    if (s_rvalid_o) begin
      $display("read of %h gave a second response at %0t", addr, $time);
      errors++;
    end
  endtask

  initial begin
    int fd;
    int idx;
    string line;
    byte op;
    logic in_sram;
    logic in_uart;
    logic [31:0] uart_count;
    soc_mem_pkg::addr_t addr;
    soc_mem_pkg::data_t data;
    soc_mem_pkg::data_t exp;
    soc_mem_pkg::data_t word;
    soc_mem_pkg::strb_t strb;
    soc_mem_pkg::resp_t rsp;
    byte op_q[$];
    soc_mem_pkg::addr_t addr_q[$];
    soc_mem_pkg::data_t data_q[$];
    soc_mem_pkg::strb_t strb_q[$];
    soc_mem_pkg::data_t exp_q[$];
    soc_mem_pkg::resp_t rsp_q[$];
    soc_mem_pkg::data_t ref_mem[int];

    clk = 1'b0;
    rst_n_i = 1'b0;
    s_awvalid_i = 1'b0;
    s_awaddr_i = '0;
    s_wvalid_i = 1'b0;
    s_wdata_i = '0;
    s_wstrb_i = '0;
    s_bready_i = 1'b0;
    s_arvalid_i = 1'b0;
    s_araddr_i = '0;
    s_rready_i = 1'b0;
    uart_count = '0;
    void'($urandom(64));

    fd = $fopen("bench/soc_mem_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/soc_mem_vectors.txt");
      $display("Finished with errors");
      $finish;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      if ($sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, exp, rsp) == 6) begin
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        strb_q.push_back(strb);
        exp_q.push_back(exp);
        rsp_q.push_back(rsp);
      end
    end
    $fclose(fd);
    limit = 200 * op_q.size() + 100;

    repeat (10) @(posedge clk);
    #5;
    rst_n_i = 1'b1;

    foreach (op_q[i]) begin
      addr = addr_q[i];
      in_sram = addr >= soc_mem_pkg::sram_base;
      in_uart = (addr >= soc_mem_pkg::uart_base) &&
                (addr < soc_mem_pkg::uart_base + soc_mem_pkg::uart_span);
      idx = int'({3'b000, addr[31:3]}) % mem_words;
      if (op_q[i] == "W") begin
        axi_write(addr, data_q[i], strb_q[i], rsp);
        check_resp($sformatf("write %h resp", addr), rsp_q[i], rsp);
        if (in_sram) begin
          word = ref_mem.exists(idx) ? ref_mem[idx] : '0;
          for (int b = 0; b < soc_mem_pkg::strb_w; b++) begin
            if (strb_q[i][b]) begin
              word[8*b +: 8] = data_q[i][8*b +: 8];
            end
          end
          ref_mem[idx] = word;
        end
        if (in_uart && strb_q[i][0]) begin
          exp_tx.push_back(data_q[i][7:0]);
          uart_count++;
        end
      end else begin
        axi_read(addr, data, rsp);
        check_resp($sformatf("read %h resp", addr), rsp_q[i], rsp);
        check_data($sformatf("read %h data", addr), exp_q[i], data);
        if (in_sram && ref_mem.exists(idx)) begin
          check_data($sformatf("sram model %h", addr), ref_mem[idx], data);
        end
        if (in_uart) begin
          check_data("uart count model", {32'h0, uart_count}, data);
        end
      end
    end

    repeat (2) @(posedge clk);
    if (tx_q.size() != exp_tx.size()) begin
      $display("uart sent %0d bytes but %0d were written", tx_q.size(), exp_tx.size());
      errors++;
    end
    foreach (exp_tx[k]) begin
      if (k < tx_q.size()) begin
        check_byte($sformatf("uart byte %0d", k), exp_tx[k], tx_q[k]);
      end
    end
    $display("%0d vectors run, %0d errors", op_q.size(), errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== bench/soc_mem_vectors.txt ====
# op addr data strb exp_rdata exp_resp, all hex
# writes ignore exp_rdata, resp 0 is okay and 3 is decerr
W 80000000 1122334455667788 ff 0000000000000000 0
R 80000000 0000000000000000 00 1122334455667788 0
W 80000008 0123456789abcdef ff 0000000000000000 0
W 80000008 a5a5a5a5a5a5a5a5 0f 0000000000000000 0
R 80000008 0000000000000000 00 01234567a5a5a5a5 0
W 80000008 ffeeddccbbaa9988 a0 0000000000000000 0
R 80000008 0000000000000000 00 ff23dd67a5a5a5a5 0
W 80002010 cafef00ddeadbeef ff 0000000000000000 0
R 80000010 0000000000000000 00 cafef00ddeadbeef 0
W 80000010 0000000000001234 03 0000000000000000 0
R 80002010 0000000000000000 00 cafef00ddead1234 0
R 10000000 0000000000000000 00 0000000000000000 0
W 10000000 0000000000000048 01 0000000000000000 0
W 10000004 0000000000000069 ff 0000000000000000 0
W 10000008 0000000000000021 fe 0000000000000000 0
R 1000000c 0000000000000000 00 0000000000000002 0
W 1000000c 000000000000000a 01 0000000000000000 0
R 10000000 0000000000000000 00 0000000000000003 0
W 20000000 ffffffffffffffff ff 0000000000000000 3
R 20000000 0000000000000000 00 0000000000000000 3
W 10000010 0000000000000055 01 0000000000000000 3
R 0ffffff8 0000000000000000 00 0000000000000000 3
W 7ffffff8 0000000000000000 ff 0000000000000000 3
R 80000000 0000000000000000 00 1122334455667788 0
R 10000004 0000000000000000 00 0000000000000003 0
W 800001f8 aaaaaaaa55555555 ff 0000000000000000 0
R 800001f8 0000000000000000 00 aaaaaaaa55555555 0
W 10000000 000000000000004f 01 0000000000000000 0
R 10000008 0000000000000000 00 0000000000000004 0

// ==== files.f ====
common/soc_mem_pkg.sv
common/axi_lite_if.sv
verilog/stall_lfsr.sv
sram/axi_sram_slave.sv
uart/axi_uart_slave.sv
verilog/axi_addr_decode.sv
verilog/soc_mem_top.sv
bench/tb_soc_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run from the project root, then look for the pass line
cd "$(dirname "$0")" && rm -f sim.log && \
  verilator --binary --timing --timescale 1ns/1ps --top-module tb_soc_mem \
    -f files.f -Mdir obj_dir -o tb_soc_mem > build.log 2>&1 && \
  ./obj_dir/tb_soc_mem > sim.log 2>&1
grep -qx "Finished with no errors" sim.log && echo "simulation passed" && exit 0 || \
  { echo "simulation failed, see build.log and sim.log"; exit 1; }
